/* design/ex_pkg.sv */
package ex_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0]     inst_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      funct3_t;
    typedef logic [3:0]      byte_en_t;    // one bit per byte lane
    typedef logic [2:0]      alu_op_t;
    typedef logic [1:0]      wb_sel_t;

    localparam int CACHE_ADDR_W_DEF = 25;
    localparam int CACHE_ADDR_USED  = 23;   // sum bits the cache decodes

    // alu selects, numbered like the OP/OP-IMM funct3 field
    localparam alu_op_t ALU_ADD  = 3'b000;
    localparam alu_op_t ALU_SLL  = 3'b001;
    localparam alu_op_t ALU_SLT  = 3'b010;
    localparam alu_op_t ALU_SLTU = 3'b011;
    localparam alu_op_t ALU_XOR  = 3'b100;
    localparam alu_op_t ALU_SRL  = 3'b101;
    localparam alu_op_t ALU_OR   = 3'b110;
    localparam alu_op_t ALU_AND  = 3'b111;

    localparam wb_sel_t WB_ALU   = 2'b00;
    localparam wb_sel_t WB_LINK  = 2'b01;   // pc + 4
    localparam wb_sel_t WB_LUI   = 2'b10;
    localparam wb_sel_t WB_AUIPC = 2'b11;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // branch funct3
    localparam funct3_t BEQ  = 3'b000;
    localparam funct3_t BNE  = 3'b001;
    localparam funct3_t BLT  = 3'b100;
    localparam funct3_t BGE  = 3'b101;
    localparam funct3_t BLTU = 3'b110;
    localparam funct3_t BGEU = 3'b111;

    // store widths
    localparam funct3_t SB = 3'b000;
    localparam funct3_t SH = 3'b001;
    localparam funct3_t SW = 3'b010;

endpackage

/* design/ex_decode.sv */
`timescale 1ns/1ps

module ex_decode (
    input  ex_pkg::inst_t     inst_i,
    output ex_pkg::reg_addr_t rd_o,
    output ex_pkg::funct3_t   funct3_o,
    output ex_pkg::alu_op_t   alu_op_o,
    output logic              use_imm_o,
    output logic              rd_we_o,
    output ex_pkg::wb_sel_t   wb_sel_o,
    output logic              is_branch_o,
    output logic              is_jump_o,
    output logic              is_load_o,
    output logic              is_store_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;

    assign opcode   = inst_i[6:0];
    assign funct7   = inst_i[31:25];
    assign rd_o     = inst_i[11:7];
    assign funct3_o = inst_i[14:12];

    // funct3 already carries the alu select for both alu formats
    assign alu_op_o = ex_pkg::alu_op_t'(funct3_o);

    always_comb begin
        use_imm_o   = 1'b0;
        rd_we_o     = 1'b0;
        wb_sel_o    = ex_pkg::WB_ALU;
        is_branch_o = 1'b0;
        is_jump_o   = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        case (opcode)
            ex_pkg::OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                rd_we_o   = 1'b1;
            end
            ex_pkg::OPC_OP: begin
                rd_we_o = (funct7 == 7'd0);   // no sub/sra/mul here
            end
            ex_pkg::OPC_BRANCH: is_branch_o = 1'b1;
            ex_pkg::OPC_JAL, ex_pkg::OPC_JALR: begin
                is_jump_o = 1'b1;
                rd_we_o   = 1'b1;
                wb_sel_o  = ex_pkg::WB_LINK;
            end
            ex_pkg::OPC_LUI: begin
                rd_we_o  = 1'b1;
                wb_sel_o = ex_pkg::WB_LUI;
            end
            ex_pkg::OPC_AUIPC: begin
                rd_we_o  = 1'b1;
                wb_sel_o = ex_pkg::WB_AUIPC;
            end
            ex_pkg::OPC_LOAD: begin
                is_load_o = 1'b1;
                rd_we_o   = 1'b1;             // data zero, real value comes later
            end
            ex_pkg::OPC_STORE: is_store_o = 1'b1;
            default: ;
        endcase
    end

endmodule

/* design/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::xlen_t   rs1_i,
    input  ex_pkg::xlen_t   rs2_i,
    input  ex_pkg::xlen_t   imm_i,
    input  ex_pkg::alu_op_t alu_op_i,
    input  logic            use_imm_i,
    output ex_pkg::xlen_t   result_o
);

    ex_pkg::xlen_t op2;
    logic [4:0]    shamt;
    logic          lt_signed;
    logic          lt_unsigned;

    assign op2   = use_imm_i ? imm_i : rs2_i;
    assign shamt = op2[4:0];

    assign lt_signed   = $signed(rs1_i) < $signed(op2);
    assign lt_unsigned = rs1_i < op2;

    always_comb begin
        case (alu_op_i)
            ex_pkg::ALU_ADD:  result_o = rs1_i + op2;
            ex_pkg::ALU_SLT:  result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_signed};
            ex_pkg::ALU_SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_unsigned};
            ex_pkg::ALU_XOR:  result_o = rs1_i ^ op2;
            ex_pkg::ALU_OR:   result_o = rs1_i | op2;
            ex_pkg::ALU_AND:  result_o = rs1_i & op2;
            ex_pkg::ALU_SLL:  result_o = rs1_i << shamt;
            ex_pkg::ALU_SRL:  result_o = rs1_i >> shamt;   // logical only
            default:          result_o = '0;
        endcase
    end

endmodule

/* design/ex_branch.sv */
`timescale 1ns/1ps

module ex_branch (
    input  ex_pkg::xlen_t   rs1_i,
    input  ex_pkg::xlen_t   rs2_i,
    input  ex_pkg::funct3_t funct3_i,
    input  logic            is_branch_i,
    input  logic            is_jump_i,
    input  ex_pkg::xlen_t   jump_base_i,
    input  ex_pkg::xlen_t   jump_offset_i,
    output logic            jump_flag_o,
    output ex_pkg::xlen_t   jump_addr_o
);

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    assign eq  = rs1_i == rs2_i;
    assign lt  = $signed(rs1_i) < $signed(rs2_i);
    assign ltu = rs1_i < rs2_i;

    always_comb begin
        case (funct3_i)
            ex_pkg::BEQ:  taken = eq;
            ex_pkg::BNE:  taken = !eq;
            ex_pkg::BLT:  taken = lt;
            ex_pkg::BGE:  taken = !lt;
            ex_pkg::BLTU: taken = ltu;
            ex_pkg::BGEU: taken = !ltu;
            default:      taken = 1'b0;
        endcase
    end

    assign jump_flag_o = is_jump_i || (is_branch_i && taken);
    assign jump_addr_o = jump_flag_o ? jump_base_i + jump_offset_i : '0;

endmodule

/* design/ex_mem_req.sv */
`timescale 1ns/1ps

module ex_mem_req #(
    parameter int CACHE_ADDR_W = ex_pkg::CACHE_ADDR_W_DEF
) (
    input  ex_pkg::xlen_t     rs1_i,
    input  ex_pkg::xlen_t     rs2_i,
    input  ex_pkg::xlen_t     imm_i,
    input  ex_pkg::funct3_t   funct3_i,
    input  ex_pkg::reg_addr_t rd_i,
    input  logic              is_load_i,
    input  logic              is_store_i,
    output logic [CACHE_ADDR_W-1:0] addr_o,
    output ex_pkg::byte_en_t  byte_en_o,
    output ex_pkg::xlen_t     wdata_o,
    output logic              read_o,
    output logic              write_o,
    output logic              hold_o,
    output ex_pkg::reg_addr_t wait_rd_o
);

    ex_pkg::xlen_t    sum;
    ex_pkg::byte_en_t store_be;

    assign sum = rs1_i + imm_i;

    always_comb begin
        case (funct3_i)
            ex_pkg::SB: store_be = 4'b0001 << sum[1:0];
            ex_pkg::SH: store_be = sum[1] ? 4'b1100 : 4'b0011;
            ex_pkg::SW: store_be = 4'b1111;
            default:    store_be = 4'b0000;   // bad width, no write
        endcase
    end

    assign write_o   = is_store_i && (store_be != 4'b0000);
    assign read_o    = is_load_i;
    assign hold_o    = is_load_i;             // stall upstream until load data returns
    assign wait_rd_o = is_load_i ? rd_i : '0;

    assign addr_o = (read_o || write_o) ?
                    CACHE_ADDR_W'(sum[ex_pkg::CACHE_ADDR_USED-1:0]) : '0;
    assign byte_en_o = write_o ? store_be : '0;
    assign wdata_o   = write_o ? rs2_i : '0;

endmodule

/* design/ex_writeback.sv */
`timescale 1ns/1ps

module ex_writeback #(
    parameter int CACHE_ADDR_W = ex_pkg::CACHE_ADDR_W_DEF
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  ex_pkg::wb_sel_t         wb_sel_i,
    input  ex_pkg::reg_addr_t       rd_i,
    input  logic                    rd_we_i,
    input  ex_pkg::xlen_t           alu_result_i,
    input  ex_pkg::xlen_t           imm_i,
    input  ex_pkg::xlen_t           pc_i,
    input  logic                    jump_flag_i,
    input  ex_pkg::xlen_t           jump_addr_i,
    input  logic [CACHE_ADDR_W-1:0] mem_addr_i,
    input  ex_pkg::byte_en_t        mem_byte_en_i,
    input  ex_pkg::xlen_t           mem_wdata_i,
    input  logic                    mem_read_i,
    input  logic                    mem_write_i,
    input  logic                    hold_i,
    input  ex_pkg::reg_addr_t       wait_rd_i,
    output ex_pkg::xlen_t           reg_wdata_o,
    output logic                    reg_we_o,
    output ex_pkg::reg_addr_t       reg_waddr_o,
    output logic                    jump_flag_o,
    output ex_pkg::xlen_t           jump_addr_o,
    output logic                    hold_flag_o,
    output logic [CACHE_ADDR_W-1:0] mem_addr_o,
    output ex_pkg::byte_en_t        mem_byte_en_o,
    output ex_pkg::xlen_t           mem_wdata_o,
    output logic                    mem_read_o,
    output logic                    mem_write_o,
    output ex_pkg::reg_addr_t       reg_wait_wb_o
);

    ex_pkg::xlen_t wdata;

    always_comb begin
        case (wb_sel_i)
            ex_pkg::WB_LINK:  wdata = pc_i + 32'd4;
            ex_pkg::WB_LUI:   wdata = imm_i;
            ex_pkg::WB_AUIPC: wdata = pc_i + imm_i;
            default:          wdata = alu_result_i;
        endcase
        if (!rd_we_i || mem_read_i) begin
            wdata = '0;                       // loads fill rd later
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_wdata_o   <= '0;
            reg_we_o      <= 1'b0;
            reg_waddr_o   <= '0;
            jump_flag_o   <= 1'b0;
            jump_addr_o   <= '0;
            hold_flag_o   <= 1'b0;
            mem_addr_o    <= '0;
            mem_byte_en_o <= '0;
            mem_wdata_o   <= '0;
            mem_read_o    <= 1'b0;
            mem_write_o   <= 1'b0;
            reg_wait_wb_o <= '0;
        end else begin
            reg_wdata_o   <= wdata;
            reg_we_o      <= rd_we_i;
            reg_waddr_o   <= rd_we_i ? rd_i : '0;
            jump_flag_o   <= jump_flag_i;
            jump_addr_o   <= jump_addr_i;
            hold_flag_o   <= hold_i;
            mem_addr_o    <= mem_addr_i;
            mem_byte_en_o <= mem_byte_en_i;
            mem_wdata_o   <= mem_wdata_i;
            mem_read_o    <= mem_read_i;
            mem_write_o   <= mem_write_i;
            reg_wait_wb_o <= wait_rd_i;
        end
    end

endmodule

/* design/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage #(
    parameter int CACHE_ADDR_W = ex_pkg::CACHE_ADDR_W_DEF
) (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  ex_pkg::inst_t           inst_i,
    input  ex_pkg::xlen_t           pc_i,
    input  ex_pkg::xlen_t           rs1_data_i,
    input  ex_pkg::xlen_t           rs2_data_i,
    input  ex_pkg::xlen_t           imm_i,          // sign-extended by decode
    input  ex_pkg::xlen_t           jump_base_i,
    input  ex_pkg::xlen_t           jump_offset_i,
    output ex_pkg::xlen_t           reg_wdata_o,
    output logic                    reg_we_o,
    output ex_pkg::reg_addr_t       reg_waddr_o,
    output logic                    jump_flag_o,
    output ex_pkg::xlen_t           jump_addr_o,
    output logic                    hold_flag_o,
    output logic [CACHE_ADDR_W-1:0] mem_addr_o,
    output ex_pkg::byte_en_t        mem_byte_en_o,
    output ex_pkg::xlen_t           mem_wdata_o,
    output logic                    mem_read_o,
    output logic                    mem_write_o,
    output ex_pkg::reg_addr_t       reg_wait_wb_o
);

    ex_pkg::reg_addr_t rd;
    ex_pkg::funct3_t   funct3;
    ex_pkg::alu_op_t   alu_op;
    ex_pkg::wb_sel_t   wb_sel;
    logic              use_imm;
    logic              rd_we;
    logic              is_branch;
    logic              is_jump;
    logic              is_load;
    logic              is_store;

    ex_pkg::xlen_t     alu_result;
    logic              jump_flag;
    ex_pkg::xlen_t     jump_addr;

    logic [CACHE_ADDR_W-1:0] mem_addr;
    ex_pkg::byte_en_t  mem_byte_en;
    ex_pkg::xlen_t     mem_wdata;
    logic              mem_read;
    logic              mem_write;
    logic              hold;
    ex_pkg::reg_addr_t wait_rd;

    ex_decode ex_decode_inst (
        .inst_i      (inst_i),
        .rd_o        (rd),
        .funct3_o    (funct3),
        .alu_op_o    (alu_op),
        .use_imm_o   (use_imm),
        .rd_we_o     (rd_we),
        .wb_sel_o    (wb_sel),
        .is_branch_o (is_branch),
        .is_jump_o   (is_jump),
        .is_load_o   (is_load),
        .is_store_o  (is_store)
    );

    ex_alu ex_alu_inst (
        .rs1_i     (rs1_data_i),
        .rs2_i     (rs2_data_i),
        .imm_i     (imm_i),
        .alu_op_i  (alu_op),
        .use_imm_i (use_imm),
        .result_o  (alu_result)
    );

    ex_branch ex_branch_inst (
        .rs1_i         (rs1_data_i),
        .rs2_i         (rs2_data_i),
        .funct3_i      (funct3),
        .is_branch_i   (is_branch),
        .is_jump_i     (is_jump),
        .jump_base_i   (jump_base_i),
        .jump_offset_i (jump_offset_i),
        .jump_flag_o   (jump_flag),
        .jump_addr_o   (jump_addr)
    );

    ex_mem_req #(
        .CACHE_ADDR_W (CACHE_ADDR_W)
    ) ex_mem_req_inst (
        .rs1_i      (rs1_data_i),
        .rs2_i      (rs2_data_i),
        .imm_i      (imm_i),
        .funct3_i   (funct3),
        .rd_i       (rd),
        .is_load_i  (is_load),
        .is_store_i (is_store),
        .addr_o     (mem_addr),
        .byte_en_o  (mem_byte_en),
        .wdata_o    (mem_wdata),
        .read_o     (mem_read),
        .write_o    (mem_write),
        .hold_o     (hold),
        .wait_rd_o  (wait_rd)
    );

    ex_writeback #(
        .CACHE_ADDR_W (CACHE_ADDR_W)
    ) ex_writeback_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wb_sel_i      (wb_sel),
        .rd_i          (rd),
        .rd_we_i       (rd_we),
        .alu_result_i  (alu_result),
        .imm_i         (imm_i),
        .pc_i          (pc_i),
        .jump_flag_i   (jump_flag),
        .jump_addr_i   (jump_addr),
        .mem_addr_i    (mem_addr),
        .mem_byte_en_i (mem_byte_en),
        .mem_wdata_i   (mem_wdata),
        .mem_read_i    (mem_read),
        .mem_write_i   (mem_write),
        .hold_i        (hold),
        .wait_rd_i     (wait_rd),
        .reg_wdata_o   (reg_wdata_o),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o),
        .hold_flag_o   (hold_flag_o),
        .mem_addr_o    (mem_addr_o),
        .mem_byte_en_o (mem_byte_en_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_read_o    (mem_read_o),
        .mem_write_o   (mem_write_o),
        .reg_wait_wb_o (reg_wait_wb_o)
    );

endmodule

/* tb/ex_vectors.svh */
// stimulus: inst, pc, rs1, rs2, imm, jump base, jump offset, random kind
// expected: reg_wdata, reg_we, reg_waddr, jump_flag, jump_addr, mem_addr,
//           byte_en, mem_wdata, mem_read (also hold), mem_write, reg_wait_wb
task load_vectors;
    begin
        add_row('h00000093, 'h0, 'h5, 'h0, 'hFFFFFFFD, 'h0, 'h0, 0,
                'h2, 1, 1, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);         // addi
        add_row('h00002113, 'h0, 'hFFFFFFFF, 'h0, 'h1, 'h0, 'h0, 0,
                'h1, 1, 2, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);         // slti, -1 < 1
        add_row('h00003193, 'h0, 'hFFFFFFFF, 'h0, 'h1, 'h0, 'h0, 0,
                'h0, 1, 3, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);         // sltiu
        add_row('h00004213, 'h0, 'hF0F0F0F0, 'h0, 'hFFFFFF00, 'h0, 'h0, 0,
                'h0F0F0FF0, 1, 4, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);
        add_row('h00006293, 'h0, 'h1200, 'h0, 'h34, 'h0, 'h0, 0,
                'h1234, 1, 5, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);      // ori
        add_row('h00007313, 'h0, 'h12345678, 'h0, 'hFF, 'h0, 'h0, 0,
                'h78, 1, 6, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);        // andi
        add_row('h00001393, 'h0, 'h1, 'h0, 'h1F, 'h0, 'h0, 0,
                'h80000000, 1, 7, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);  // slli
        add_row('h00005413, 'h0, 'h80000000, 'h0, 'h4, 'h0, 'h0, 0,
                'h08000000, 1, 8, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);  // srli
        add_row('h000004B3, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 1,
                'h0, 1, 9, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);         // add, random
        add_row('h00001533, 'h0, 'h3, 'h24, 'h0, 'h0, 'h0, 0,
                'h30, 1, 10, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);       // sll, shamt 4
        add_row('h000025B3, 'h0, 'h80000000, 'h1, 'h0, 'h0, 'h0, 0,
                'h1, 1, 11, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);        // slt
        add_row('h00003633, 'h0, 'h80000000, 'h1, 'h0, 'h0, 'h0, 0,
                'h0, 1, 12, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);        // sltu
        add_row('h000046B3, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 2,
                'h0, 1, 13, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);        // xor, random
        add_row('h00005733, 'h0, 'hFFFFFFFF, 'h1C, 'h0, 'h0, 'h0, 0,
                'hF, 1, 14, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);        // srl
        add_row('h000067B3, 'h0, 'hA0, 'h0B, 'h0, 'h0, 'h0, 0,
                'hAB, 1, 15, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);       // or
        add_row('h00007833, 'h0, 'hFF00, 'h0FF0, 'h0, 'h0, 'h0, 0,
                'hF00, 1, 16, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);      // and
        add_row('h400008B3, 'h0, 'h5, 'h3, 'h0, 'h0, 'h0, 0,
                'h0, 0, 0, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);         // sub, no write
        add_row('h00000063, 'h0, 'h7, 'h7, 'h0, 'h100, 'h20, 0,
                'h0, 0, 0, 1, 'h120, 'h0, 'h0, 'h0, 0, 0, 0);       // beq taken
        add_row('h00001063, 'h0, 'h7, 'h7, 'h0, 'h100, 'h20, 0,
                'h0, 0, 0, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);         // bne not taken
        add_row('h00004063, 'h0, 'hFFFFFFFF, 'h1, 'h0, 'h100, 'h20, 0,
                'h0, 0, 0, 1, 'h120, 'h0, 'h0, 'h0, 0, 0, 0);       // blt taken
        add_row('h00005063, 'h0, 'hFFFFFFFF, 'h1, 'h0, 'h100, 'h20, 0,
                'h0, 0, 0, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);         // bge not taken
        add_row('h00006063, 'h0, 'h0, 'h0, 'h0, 'h100, 'h20, 3,
                'h0, 0, 0, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);         // bltu, random
        add_row('h00007063, 'h0, 'hFFFFFFFF, 'h1, 'h0, 'h100, 'h20, 0,
                'h0, 0, 0, 1, 'h120, 'h0, 'h0, 'h0, 0, 0, 0);       // bgeu taken
        add_row('h000000EF, 'h200, 'h0, 'h0, 'h0, 'h200, 'h40, 0,
                'h204, 1, 1, 1, 'h240, 'h0, 'h0, 'h0, 0, 0, 0);     // jal
        add_row('h000002E7, 'h300, 'h0, 'h0, 'h0, 'h1000, 'h8, 0,
                'h304, 1, 5, 1, 'h1008, 'h0, 'h0, 'h0, 0, 0, 0);    // jalr
        add_row('h00000337, 'h0, 'h0, 'h0, 'h12345000, 'h0, 'h0, 0,
                'h12345000, 1, 6, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);  // lui
        add_row('h00000397, 'h400, 'h0, 'h0, 'h1000, 'h0, 'h0, 0,
                'h1400, 1, 7, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);      // auipc
        add_row('h00000023, 'h0, 'h1000, 'hAA, 'h3, 'h0, 'h0, 0,
                'h0, 0, 0, 0, 'h0, 'h1003, 'h8, 'hAA, 0, 1, 0);     // sb
        add_row('h00001023, 'h0, 'h2000, 'hBEEF, 'h2, 'h0, 'h0, 0,
                'h0, 0, 0, 0, 'h0, 'h2002, 'hC, 'hBEEF, 0, 1, 0);   // sh, upper half
        add_row('h00002023, 'h0, 'h0, 'h0, 'h40, 'h0, 'h0, 4,
                'h0, 0, 0, 0, 'h0, 'h0, 'h0, 'h0, 0, 0, 0);         // sw, random
        add_row('h00002023, 'h0, 'hFFF00000, 'h55, 'h10, 'h0, 'h0, 0,
                'h0, 0, 0, 0, 'h0, 'h700010, 'hF, 'h55, 0, 1, 0);   // high bits dropped
        add_row('h00002483, 'h0, 'h3000, 'h0, 'h4, 'h0, 'h0, 0,
                'h0, 1, 9, 0, 'h0, 'h3004, 'h0, 'h0, 1, 0, 9);      // lw
    end
endtask

/* tb/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage;

    typedef struct packed {
        logic [31:0] inst, pc, rs1, rs2, imm, base, off;
        int          kind;                   // 0 fixed, else random operands
        logic [31:0] wdata, ja, maddr, mwdata;
        logic [4:0]  waddr, wait_rd;
        logic [3:0]  be;
        logic        we, jf, rd, wr;
    } row_t;

    logic clk, rst_n;
    logic [31:0] inst, pc, rs1, rs2, imm, base, off;
    logic [31:0] reg_wdata, jump_addr, mem_wdata;
    logic [24:0] mem_addr;
    logic [4:0]  reg_waddr, reg_wait_wb;
    logic [3:0]  mem_byte_en;
    logic        reg_we, jump_flag, hold_flag, mem_read, mem_write;

    row_t vectors[$];
    int   errors;
    bit   timed_out;

    ex_stage #(.CACHE_ADDR_W(25)) ex_stage_inst (
        .clk_i(clk), .rst_n_i(rst_n), .inst_i(inst), .pc_i(pc),
        .rs1_data_i(rs1), .rs2_data_i(rs2), .imm_i(imm),
        .jump_base_i(base), .jump_offset_i(off),
        .reg_wdata_o(reg_wdata), .reg_we_o(reg_we), .reg_waddr_o(reg_waddr),
        .jump_flag_o(jump_flag), .jump_addr_o(jump_addr), .hold_flag_o(hold_flag),
        .mem_addr_o(mem_addr), .mem_byte_en_o(mem_byte_en), .mem_wdata_o(mem_wdata),
        .mem_read_o(mem_read), .mem_write_o(mem_write), .reg_wait_wb_o(reg_wait_wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task add_row(input logic [31:0] i_inst, i_pc, i_rs1, i_rs2, i_imm, i_base, i_off,
                 input int i_kind, input logic [31:0] e_wdata, input logic e_we,
                 input logic [4:0] e_waddr, input logic e_jf, input logic [31:0] e_ja,
                 input logic [31:0] e_maddr, input logic [3:0] e_be,
                 input logic [31:0] e_mwdata, input logic e_rd, input logic e_wr,
                 input logic [4:0] e_wait);
        row_t r;
        begin
            r.inst = i_inst;
            r.pc = i_pc;
            r.rs1 = i_rs1;
            r.rs2 = i_rs2;
            r.imm = i_imm;
            r.base = i_base;
            r.off = i_off;
            r.kind = i_kind;
            r.wdata = e_wdata;
            r.we = e_we;
            r.waddr = e_waddr;
            r.jf = e_jf;
            r.ja = e_ja;
            r.maddr = e_maddr;
            r.be = e_be;
            r.mwdata = e_mwdata;
            r.rd = e_rd;
            r.wr = e_wr;
            r.wait_rd = e_wait;
            vectors.push_back(r);
        end
    endtask

    `include "ex_vectors.svh"

    // random operands, expected values from the stage rules
    function automatic row_t fill_random_row(row_t r);
        logic [31:0] sum;
        r.rs1 = $urandom;
        r.rs2 = $urandom;
        case (r.kind)
            1: r.wdata = r.rs1 + r.rs2;
            2: r.wdata = r.rs1 ^ r.rs2;
            3: begin
                r.jf = r.rs1 < r.rs2;
                r.ja = r.jf ? r.base + r.off : 32'h0;
            end
            default: begin
                sum      = r.rs1 + r.imm;
                r.maddr  = {9'h0, sum[22:0]};
                r.be     = 4'hF;
                r.mwdata = r.rs2;
                r.wr     = 1'b1;
            end
        endcase
        return r;
    endfunction

    task check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task wait_falling_edge;
        int t;
        begin
            t = 0;
            while (clk !== 1'b1 && t < 200) begin
                #1;
                t++;
            end
            while (clk !== 1'b0 && t < 200) begin
                #1;
                t++;
            end
            if (t >= 200) begin
                $display("Timeout: the clock stopped toggling");
                timed_out = 1'b1;
            end
        end
    endtask

    task drive_row(input row_t r);
        inst = r.inst;
        pc = r.pc;
        rs1 = r.rs1;
        rs2 = r.rs2;
        imm = r.imm;
        base = r.base;
        off = r.off;
    endtask

    task check_row(input int n, input row_t r);
        string tag;
        begin
            tag = $sformatf("row %0d", n);
            check_value({tag, " reg_wdata_o"}, reg_wdata, r.wdata);
            check_value({tag, " reg_we_o"}, reg_we, r.we);
            check_value({tag, " reg_waddr_o"}, reg_waddr, r.waddr);
            check_value({tag, " jump_flag_o"}, jump_flag, r.jf);
            check_value({tag, " jump_addr_o"}, jump_addr, r.ja);
            check_value({tag, " hold_flag_o"}, hold_flag, r.rd);
            check_value({tag, " mem_addr_o"}, mem_addr, r.maddr);
            check_value({tag, " mem_byte_en_o"}, mem_byte_en, r.be);
            check_value({tag, " mem_wdata_o"}, mem_wdata, r.mwdata);
            check_value({tag, " mem_read_o"}, mem_read, r.rd);
            check_value({tag, " mem_write_o"}, mem_write, r.wr);
            check_value({tag, " reg_wait_wb_o"}, reg_wait_wb, r.wait_rd);
        end
    endtask

    initial begin
        row_t zero_row;
        int   seed_val;
        errors = 0;
        timed_out = 1'b0;
        seed_val = $urandom(42);
        rst_n = 1'b0;
        inst = '0;
        pc = '0;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        base = '0;
        off = '0;
        zero_row = '0;
        load_vectors();
        for (int i = 0; i < vectors.size(); i++) begin
            if (vectors[i].kind != 0) vectors[i] = fill_random_row(vectors[i]);
        end
        wait_falling_edge();
        wait_falling_edge();
        check_row(-1, zero_row);             // during reset
        rst_n = 1'b1;
        wait_falling_edge();
        check_row(-1, zero_row);             // opcode 0 does nothing
        drive_row(vectors[0]);
        for (int i = 1; i <= vectors.size(); i++) begin
            if (timed_out) break;
            wait_falling_edge();
            if (i < vectors.size()) begin
                drive_row(vectors[i]);
            end
            #1;                              // next row applied, outputs still hold this one
            check_row(i - 1, vectors[i - 1]);
        end
        $display("Errors: %0d", errors);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+tb
design/ex_pkg.sv
design/ex_decode.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_mem_req.sv
design/ex_writeback.sv
design/ex_stage.sv
tb/tb_ex_stage.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - design/ex_pkg.sv
  - design/ex_decode.sv
  - design/ex_alu.sv
  - design/ex_branch.sv
  - design/ex_mem_req.sv
  - design/ex_writeback.sv
  - design/ex_stage.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_ex_stage.sv
